// ==== Makefile ====
# Verilator build and run for the Barrett reduction testbench

VERILATOR := verilator
VFLAGS    := --binary --timing -j 0 --timescale 1ns/100ps
TOP       := barrett_mod_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run may end in $$fatal, so the log decides the result
test: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== compile.f ====
verilog/mod_arith_pkg.sv
verilog/pipe_ctl_pkg.sv
verilog/int_mult_pipe.sv
verilog/residue_fifo.sv
verilog/barrett_mod_pipe.sv
verilog/barrett_mod_top.sv
verif/barrett_mod_tb.sv

// ==== verif/barrett_mod_tb.sv ====
// barrett_mod_tb
// Testbench for the Barrett reduction subsystem. Sends values below P*P
// with random tags, input gaps and output back-pressure, and checks each
// remainder, its tag, the result order, the latency and the error flag
// against a queue model.
`timescale 1ns/100ps

module barrett_mod_tb
  import mod_arith_pkg::*, pipe_ctl_pkg::*;
;

  localparam int    N_ITEMS     = 400;
  localparam int    N_LAT       = 4;               // isolated latency items
  localparam int    N_CORNER    = 8;               // directed values up front
  localparam int    LAT_STAGES  = 10;              // registers from input to output
  localparam int    TIMEOUT_CYC = 20*N_ITEMS + 200;
  localparam wide_t PSQ         = wide_t'(MOD_P) * wide_t'(MOD_P); // input bound

  logic  i_clk;
  logic  i_rst;
  wide_t i_dat;
  logic  i_val;
  ctl_t  i_ctl;
  logic  o_rdy;
  dat_t  o_dat;
  ctl_t  o_ctl;
  logic  o_val;
  logic  i_rdy;
  logic  o_err;

  int    seed;
  int    cyc;                                      // rising edges so far
  int    n_out;                                    // results taken
  dat_t  exp_dat_q[$];                             // model remainders in order
  ctl_t  exp_ctl_q[$];                             // model tags in order
  logic  stall_hold;                               // result stalled last cycle
  dat_t  held_dat;
  ctl_t  held_ctl;

  barrett_mod_top uut (
    .i_clk (i_clk), .i_rst (i_rst),
    .i_dat (i_dat), .i_val (i_val), .i_ctl (i_ctl), .o_rdy (o_rdy),
    .o_dat (o_dat), .o_ctl (o_ctl), .o_val (o_val), .i_rdy (i_rdy),
    .o_err (o_err)
  );

  always #10 i_clk = ~i_clk;                       // 20 ns period

  task automatic end_with_failure();
    $display("TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_problem(string what);
    $display("error at %0t: %s", $time, what);
    end_with_failure();
  endtask

  task automatic check_dat(string name, dat_t exp, dat_t act);
    if (act !== exp) begin
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
      end_with_failure();
    end
  endtask

  task automatic check_ctl(string name, ctl_t exp, ctl_t act);
    if (act !== exp) begin
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
      end_with_failure();
    end
  endtask

  task automatic check_err(logic exp, logic act);
    if (act !== exp) begin
      $display("mismatch at %0t: o_err expected %b got %b", $time, exp, act);
      end_with_failure();
    end
  endtask

  function automatic int rand_below(int n);
    return ($random(seed) & 32'h7fff_ffff) % n;    // non-negative draw
  endfunction

  function automatic wide_t random_input();
    wide_t x;
    x = wide_t'($random(seed));
    if (rand_below(8) == 0) begin
      x = x % (wide_t'(MOD_P) << 1);               // small values near P
    end else if (x >= PSQ) begin
      x = x - PSQ;                                 // fold back below P*P
    end
    return x;
  endfunction

  function automatic wide_t corner_input(int idx);
    case (idx)
      0:       return '0;
      1:       return wide_t'(MOD_P) - 1;
      2:       return wide_t'(MOD_P);
      3:       return wide_t'(MOD_P) + 1;
      4:       return (wide_t'(MOD_P) << 1) - 1;
      5:       return PSQ - 1;                     // largest legal input
      6:       return PSQ - wide_t'(MOD_P);
      default: return 32'h0001_0000;
    endcase
  endfunction

  // one item into an idle pipe with i_rdy held high
  task automatic measure_latency(wide_t x, ctl_t tag);
    int acc_edge;
    @(posedge i_clk);
    #1;
    i_dat = x;
    i_ctl = tag;
    i_val = 1'b1;
    @(negedge i_clk);
    while (o_rdy !== 1'b1) begin
      @(negedge i_clk);
    end
    acc_edge = cyc + 1;                            // transfer on the coming edge
    @(posedge i_clk);
    #1;
    i_val = 1'b0;
    while (o_val !== 1'b1) begin
      @(negedge i_clk);
    end
    // accept edge loads the first of the registers
    if (cyc - acc_edge + 1 != LAT_STAGES) begin
      $display("mismatch at %0t: o_val latency expected %0d got %0d",
               $time, LAT_STAGES, cyc - acc_edge + 1);
      end_with_failure();
    end
  endtask

  // random gaps on i_val and i_rdy low about 30% of the cycles
  task automatic send_stream(int count);
    int   sent;
    logic took;
    sent = 0;
    took = 1'b0;
    while (sent < count || i_val) begin
      @(posedge i_clk);
      #1;
      if (!i_val || took) begin
        if (sent < count && rand_below(4) != 0) begin
          i_dat = (sent < N_CORNER) ? corner_input(sent) : random_input();
          i_ctl = ctl_t'($random(seed));
          i_val = 1'b1;
          sent++;
        end else begin
          i_val = 1'b0;                            // idle cycle
        end
      end
      i_rdy = (rand_below(10) >= 3);
      @(negedge i_clk);
      took = i_val & o_rdy;                        // transfer on next edge
    end
  endtask

  always @(posedge i_clk) begin
    cyc = cyc + 1;
    if (cyc >= TIMEOUT_CYC) begin
      report_problem($sformatf("timeout after %0d cycles with %0d results outstanding",
                               cyc, exp_dat_q.size()));
    end
  end

  // scoreboard sampled mid-cycle where handshakes are settled
  always @(negedge i_clk) begin
    if (cyc > 0) begin
      check_err(1'b0, o_err);                      // inputs stay below P*P
      if (i_rst) begin
        if (o_val !== 1'b0) begin
          report_problem("o_val high during reset");
        end
      end else begin
        if (stall_hold) begin
          if (o_val !== 1'b1) begin
            report_problem("o_val dropped while i_rdy was low");
          end
          check_dat("o_dat while stalled", held_dat, o_dat);
          check_ctl("o_ctl while stalled", held_ctl, o_ctl);
        end
        stall_hold = o_val & ~i_rdy;
        held_dat   = o_dat;
        held_ctl   = o_ctl;
        if (o_val && i_rdy) begin
          if (exp_dat_q.size() == 0) begin
            report_problem("output transfer with no item outstanding");
          end else begin
            check_dat("o_dat", exp_dat_q.pop_front(), o_dat);
            check_ctl("o_ctl", exp_ctl_q.pop_front(), o_ctl);
            n_out++;
          end
        end
        if (i_val && o_rdy) begin
          exp_dat_q.push_back(dat_t'(i_dat % wide_t'(MOD_P))); // x mod P
          exp_ctl_q.push_back(i_ctl);
        end
      end
    end
  end

  initial begin
    i_clk      = 1'b0;
    i_rst      = 1'b1;
    i_dat      = '0;
    i_val      = 1'b0;
    i_ctl      = '0;
    i_rdy      = 1'b1;
    seed       = 32'hc5d3_0f12;
    cyc        = 0;
    n_out      = 0;
    stall_hold = 1'b0;
    held_dat   = '0;
    held_ctl   = '0;
    repeat (4) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    @(negedge i_clk);
    if (o_val !== 1'b0) begin
      report_problem("o_val high right after reset");
    end
    if (o_rdy !== 1'b1) begin
      report_problem("o_rdy low right after reset");   // empty pipe must accept
    end
    for (int i = 0; i < N_LAT; i++) begin
      measure_latency(random_input(), ctl_t'($random(seed)));
    end
    send_stream(N_ITEMS - N_LAT);
    @(posedge i_clk);
    #1;
    i_rdy = 1'b1;                                  // drain what is left
    while (exp_dat_q.size() != 0) begin
      @(posedge i_clk);
    end
    repeat (20) @(posedge i_clk);                  // room for a stray extra result
    if (exp_dat_q.size() != 0 || n_out != N_ITEMS) begin
      report_problem($sformatf("%0d results returned for %0d items sent", n_out, N_ITEMS));
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

// ==== verilog/barrett_mod_pipe.sv ====
// barrett_mod_pipe
// Four-stage Barrett reduction of a 32-bit input modulo the fixed prime P.
// Stage 1 feeds the quotient estimate multiply, stage 2 feeds q*P,
// stage 3 subtracts from the stored low input bits and stage 4 applies
// the final conditional subtraction. The low bits wait in a residue FIFO.
// o_err is sticky and flags an intermediate value above 2P.
`timescale 1ns/100ps

module barrett_mod_pipe
  import mod_arith_pkg::*, pipe_ctl_pkg::*;
(
  input  logic   i_clk,
  input  logic   i_rst,
  // input stream
  input  wide_t  i_dat,                // must be below P*P
  input  logic   i_val,
  input  ctl_t   i_ctl,
  output logic   o_rdy,
  // output stream
  output dat_t   o_dat,                // canonical remainder
  output ctl_t   o_ctl,
  output logic   o_val,
  input  logic   i_rdy,
  output logic   o_err,                // sticky range error
  // mult0 request, x_hi * U
  output dat_t   o_m0_a,
  output recip_t o_m0_b,
  output ctl_t   o_m0_ctl,
  output logic   o_m0_val,
  input  logic   i_m0_rdy,
  // mult0 response
  input  prod_t  i_m0_prod,
  input  ctl_t   i_m0_ctl,
  input  logic   i_m0_val,
  output logic   o_m0_rdy,
  // mult1 request, q * P
  output dat_t   o_m1_a,
  output dat_t   o_m1_b,
  output ctl_t   o_m1_ctl,
  output logic   o_m1_val,
  input  logic   i_m1_rdy,
  // mult1 response
  input  prod_t  i_m1_prod,
  input  ctl_t   i_m1_ctl,
  input  logic   i_m1_val,
  output logic   o_m1_rdy
);

  logic s1_en;                         // stage 1 may load
  logic s2_en;                         // stage 2 may load
  logic s3_en;                         // stage 3 may load
  logic s4_en;                         // stage 4 may load
  logic in_take;                       // input transfer this cycle
  logic s3_take;                       // mult1 response transfer

  logic fifo_full;
  logic fifo_empty;
  rem_t fifo_head;                     // low input bits of oldest item

  logic s3_val;                        // stage 3 output register
  ctl_t s3_ctl;
  rem_t s3_dat;                        // x - q*P, below 3P
  rem_t s4_sub;                        // s3_dat - P

  // each stage loads when empty or when its consumer takes the item
  assign s1_en = ~o_m0_val | i_m0_rdy;
  assign s2_en = ~o_m1_val | i_m1_rdy;
  assign s3_en = ~s3_val   | s4_en;
  assign s4_en = ~o_val    | i_rdy;

  // input stalls while the residue FIFO is full
  assign o_rdy   = s1_en & ~fifo_full;
  assign in_take = i_val & o_rdy;

  assign o_m0_b = BAR_U;               // constant reciprocal operand
  assign o_m1_b = MOD_P;               // constant modulus operand

  // stage 1, x >> (2K-2) towards mult0
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_m0_val <= 1'b0;
    end else if (s1_en) begin
      o_m0_val <= in_take;
    end
  end

  always_ff @(posedge i_clk) begin
    if (s1_en) begin
      o_m0_a   <= i_dat[SHIFT_IN +: DAT_BITS]; // upper input bits
      o_m0_ctl <= i_ctl;
    end
  end

  // stage 2, q = (x_hi * U) >> (2K+2) towards mult1
  assign o_m0_rdy = s2_en;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_m1_val <= 1'b0;
    end else if (s2_en) begin
      o_m1_val <= i_m0_val;
    end
  end

  always_ff @(posedge i_clk) begin
    if (s2_en) begin
      o_m1_a   <= i_m0_prod[SHIFT_Q +: DAT_BITS]; // q fits below P
      o_m1_ctl <= i_m0_ctl;
    end
  end

  // stage 3, (x - q*P) mod 2^REM_BITS
  // response waits until its residue is at the FIFO head
  assign o_m1_rdy = s3_en & ~fifo_empty;
  assign s3_take  = i_m1_val & o_m1_rdy;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      s3_val <= 1'b0;
    end else if (s3_en) begin
      s3_val <= s3_take;
    end
  end

  always_ff @(posedge i_clk) begin
    if (s3_en) begin
      s3_dat <= fifo_head - i_m1_prod[REM_BITS-1:0]; // wraps mod 2^20
      s3_ctl <= i_m1_ctl;
    end
  end

  // stage 4, one conditional subtraction of P
  assign s4_sub = s3_dat - REM_P;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_val <= 1'b0;
      o_err <= 1'b0;
    end else if (s4_en) begin
      o_val <= s3_val;
      if (s3_val && (s3_dat > REM_2P)) begin
        o_err <= 1'b1;                // stays set until reset
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (s4_en) begin
      o_ctl <= s3_ctl;
      o_dat <= (s3_dat >= REM_P) ? s4_sub[DAT_BITS-1:0] : s3_dat[DAT_BITS-1:0];
    end
  end

  // low input bits, pushed on accept and popped with the mult1 result
  residue_fifo u_fifo (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_push  (in_take),
    .i_dat   (i_dat[REM_BITS-1:0]),
    .o_full  (fifo_full),
    .i_pop   (s3_take),
    .o_dat   (fifo_head),
    .o_empty (fifo_empty)
  );

endmodule

// ==== verilog/barrett_mod_top.sv ====
// barrett_mod_top
// Barrett modular reduction subsystem. The reduction pipe drives two
// dedicated pipelined multipliers, one for the quotient estimate and
// one for the quotient times P.
`timescale 1ns/100ps

module barrett_mod_top
  import mod_arith_pkg::*, pipe_ctl_pkg::*;
(
  input  logic  i_clk,
  input  logic  i_rst,
  input  wide_t i_dat,
  input  logic  i_val,
  input  ctl_t  i_ctl,
  output logic  o_rdy,
  output dat_t  o_dat,
  output ctl_t  o_ctl,
  output logic  o_val,
  input  logic  i_rdy,
  output logic  o_err
);

  // mult0 links
  dat_t   m0_a;
  recip_t m0_b;
  ctl_t   m0_ctl;
  logic   m0_val;
  logic   m0_rdy;
  prod_t  m0_prod;
  ctl_t   m0_pctl;                     // response tag
  logic   m0_pval;
  logic   m0_prdy;

  // mult1 links
  dat_t   m1_a;
  dat_t   m1_b;
  ctl_t   m1_ctl;
  logic   m1_val;
  logic   m1_rdy;
  prod_t  m1_prod;
  ctl_t   m1_pctl;
  logic   m1_pval;
  logic   m1_prdy;

  barrett_mod_pipe u_pipe (
    .i_clk     (i_clk),   .i_rst    (i_rst),
    .i_dat     (i_dat),   .i_val    (i_val),   .i_ctl    (i_ctl),  .o_rdy  (o_rdy),
    .o_dat     (o_dat),   .o_ctl    (o_ctl),   .o_val    (o_val),  .i_rdy  (i_rdy),
    .o_err     (o_err),
    .o_m0_a    (m0_a),    .o_m0_b   (m0_b),    .o_m0_ctl (m0_ctl),
    .o_m0_val  (m0_val),  .i_m0_rdy (m0_rdy),
    .i_m0_prod (m0_prod), .i_m0_ctl (m0_pctl), .i_m0_val (m0_pval),
    .o_m0_rdy  (m0_prdy),
    .o_m1_a    (m1_a),    .o_m1_b   (m1_b),    .o_m1_ctl (m1_ctl),
    .o_m1_val  (m1_val),  .i_m1_rdy (m1_rdy),
    .i_m1_prod (m1_prod), .i_m1_ctl (m1_pctl), .i_m1_val (m1_pval),
    .o_m1_rdy  (m1_prdy)
  );

  // quotient estimate, x_hi * U
  int_mult_pipe #(.A_BITS(DAT_BITS), .B_BITS(RECIP_BITS)) u_mult_quot (
    .i_clk  (i_clk),   .i_rst (i_rst),
    .i_a    (m0_a),    .i_b   (m0_b),    .i_ctl (m0_ctl),  .i_val (m0_val),
    .o_rdy  (m0_rdy),
    .o_prod (m0_prod), .o_ctl (m0_pctl), .o_val (m0_pval), .i_rdy (m0_prdy)
  );

  // quotient times modulus, q * P
  int_mult_pipe #(.A_BITS(DAT_BITS), .B_BITS(DAT_BITS)) u_mult_prod (
    .i_clk  (i_clk),   .i_rst (i_rst),
    .i_a    (m1_a),    .i_b   (m1_b),    .i_ctl (m1_ctl),  .i_val (m1_val),
    .o_rdy  (m1_rdy),
    .o_prod (m1_prod), .o_ctl (m1_pctl), .o_val (m1_pval), .i_rdy (m1_prdy)
  );

endmodule

// ==== verilog/int_mult_pipe.sv ====
// int_mult_pipe
// Pipelined unsigned integer multiplier with valid/ready flow control.
// The product is formed at the accept edge and shifted through MULT_LAT
// registers; the tag and valid travel alongside. A single enable from
// downstream ready freezes every stage under back-pressure.
`timescale 1ns/100ps

module int_mult_pipe
  import mod_arith_pkg::*, pipe_ctl_pkg::*;
#(
  parameter int A_BITS = 16,
  parameter int B_BITS = 16
)(
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic [A_BITS-1:0] i_a,       // operand a
  input  logic [B_BITS-1:0] i_b,       // operand b
  input  ctl_t              i_ctl,     // request tag
  input  logic              i_val,
  output logic              o_rdy,
  output prod_t             o_prod,    // a*b, zero extended
  output ctl_t              o_ctl,     // tag matching o_prod
  output logic              o_val,
  input  logic              i_rdy
);

  logic [MULT_LAT-1:0] val_q;          // valid per stage
  prod_t               prod_q [MULT_LAT]; // product per stage
  ctl_t                ctl_q  [MULT_LAT]; // tag per stage
  logic                en;             // shared stage enable

  // move when the last stage is empty or being drained
  assign en    = ~val_q[MULT_LAT-1] | i_rdy;
  assign o_rdy = en;

  // valid chain cleared on reset
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      val_q <= '0;
    end else if (en) begin
      val_q <= {val_q[MULT_LAT-2:0], i_val}; // shift in new valid
    end
  end

  // payload chain
  always_ff @(posedge i_clk) begin
    if (en) begin
      prod_q[0] <= prod_t'(i_a) * prod_t'(i_b); // multiply at accept
      ctl_q[0]  <= i_ctl;
      for (int i = 1; i < MULT_LAT; i++) begin
        prod_q[i] <= prod_q[i-1];     // carry product forward
        ctl_q[i]  <= ctl_q[i-1];      // tag follows product
      end
    end
  end

  assign o_prod = prod_q[MULT_LAT-1]; // last stage drives response
  assign o_ctl  = ctl_q[MULT_LAT-1];
  assign o_val  = val_q[MULT_LAT-1];

endmodule

// ==== verilog/mod_arith_pkg.sv ====
// mod_arith_pkg
// Modulus constants and data widths for the fixed-prime Barrett reduction.
// P is the largest 16-bit prime, inputs are limited to values below P*P.
package mod_arith_pkg;

  localparam int DAT_BITS   = 16;              // remainder width
  localparam int WIDE_BITS  = 2*DAT_BITS;      // input width
  localparam int RECIP_BITS = 21;              // reciprocal width
  localparam int PROD_BITS  = 40;              // multiplier product width

  typedef logic [DAT_BITS-1:0]   dat_t;        // canonical remainder
  typedef logic [WIDE_BITS-1:0]  wide_t;       // raw input value
  typedef logic [RECIP_BITS-1:0] recip_t;      // reciprocal operand
  typedef logic [PROD_BITS-1:0]  prod_t;       // full product

  localparam dat_t MOD_P = 16'd65521;          // fixed prime modulus

  localparam int BAR_K = $clog2(MOD_P)/2 + 1;  // 9 for a 16-bit P

  // floor(2^4K / P), 1048816 for this P
  localparam recip_t BAR_U = recip_t'((64'd1 << (4*BAR_K)) / 64'(MOD_P));

  localparam int REM_BITS = 2*BAR_K + 2;       // residue width, 20

  typedef logic [REM_BITS-1:0] rem_t;          // truncated residue

  localparam int SHIFT_IN = 2*BAR_K - 2;       // input shift before mult0
  localparam int SHIFT_Q  = 2*BAR_K + 2;       // product shift after mult0

  // bounds used by the final correction stage
  localparam rem_t REM_P   = rem_t'(MOD_P);    // P at residue width
  localparam rem_t REM_2P  = REM_P << 1;       // error threshold

endpackage

// ==== verilog/pipe_ctl_pkg.sv ====
// pipe_ctl_pkg
// Stream plumbing constants: tag width, residue FIFO size and
// multiplier pipeline depth.
package pipe_ctl_pkg;

  localparam int CTL_BITS = 8;                 // tag width

  typedef logic [CTL_BITS-1:0] ctl_t;          // tag carried by each item

  localparam int FIFO_DEPTH = 16;              // residue entries
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH); // 4

  localparam int MULT_LAT = 3;                 // multiplier register stages

  // occupancy count is one bit wider than the address
  typedef logic [FIFO_AW:0] fifo_cnt_t;

endpackage

// ==== verilog/residue_fifo.sv ====
// residue_fifo
// Synchronous circular-buffer FIFO for the low input bits. Each entry
// waits here until its mult1 product reaches the subtract stage.
// Push and pop may happen in the same cycle; the head is read
// combinationally from the read pointer.
`timescale 1ns/100ps

module residue_fifo
  import mod_arith_pkg::*, pipe_ctl_pkg::*;
(
  input  logic i_clk,
  input  logic i_rst,
  input  logic i_push,                 // write enable
  input  rem_t i_dat,                  // residue to store
  output logic o_full,
  input  logic i_pop,                  // read enable
  output rem_t o_dat,                  // head of queue
  output logic o_empty
);

  rem_t               mem [FIFO_DEPTH]; // entry storage
  logic [FIFO_AW-1:0] wr_ptr;          // next slot to write
  logic [FIFO_AW-1:0] rd_ptr;          // current head slot
  fifo_cnt_t          count;           // entries held
  logic               wr_en;
  logic               rd_en;

  assign o_full  = (count == fifo_cnt_t'(FIFO_DEPTH));
  assign o_empty = (count == '0);

  // drop requests that would overflow or underflow
  assign wr_en = i_push & ~o_full;
  assign rd_en = i_pop  & ~o_empty;

  always_ff @(posedge i_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= i_dat;           // write at the edge
    end
  end

  // pointers and count cleared on reset
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;      // wraps at depth
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1; // push only
        2'b01:   count <= count - 1'b1; // pop only
        default: count <= count;        // both or none
      endcase
    end
  end

  assign o_dat = mem[rd_ptr];         // head visible after first push

endmodule
